//--- source/isa_pkg.sv
// RV32IM encoding types
`default_nettype none

package isa_pkg;

    ////////////////////////////////////////////////////////////
    // major opcodes and function fields
    ////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        LOAD     = 7'b0000011,
        MISC_MEM = 7'b0001111,
        OP_IMM   = 7'b0010011,
        AUIPC    = 7'b0010111,
        STORE    = 7'b0100011,
        OP       = 7'b0110011,
        LUI      = 7'b0110111,
        BRANCH   = 7'b1100011,
        JALR     = 7'b1100111,
        JAL      = 7'b1101111,
        SYSTEM   = 7'b1110011
    } opcode_e;

    // funct7 groups under OP
    localparam logic [6:0] funct7_base   = 7'b0000000;
    localparam logic [6:0] funct7_alt    = 7'b0100000;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    // the only SYSTEM word with funct3 of zero we accept
    localparam logic [31:0] wfi_inst = 32'h1050_0073;

    ////////////////////////////////////////////////////////////
    // control encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'd0,
        OPA_IS_NPC  = 2'd1,
        OPA_IS_PC   = 2'd2,
        OPA_IS_ZERO = 2'd3
    } opa_sel_e;

    // stores and branches read rs2 here, immediate goes out separately
    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'd0,
        OPB_IS_I_IMM = 3'd1,
        OPB_IS_S_IMM = 3'd2,
        OPB_IS_B_IMM = 3'd3,
        OPB_IS_U_IMM = 3'd4,
        OPB_IS_J_IMM = 3'd5
    } opb_sel_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLT    = 4'd2,
        SLTU   = 4'd3,
        AND    = 4'd4,
        OR     = 4'd5,
        XOR    = 4'd6,
        SLL    = 4'd7,
        SRL    = 4'd8,
        SRA    = 4'd9,
        MUL    = 4'd10,
        MULH   = 4'd11,
        MULHSU = 4'd12,
        MULHU  = 4'd13
    } alu_func_e;

    typedef enum logic [2:0] {
        FU_ALU    = 3'd0,
        FU_MULT   = 3'd1,
        FU_LSU    = 3'd2,
        FU_BRANCH = 3'd3,
        FU_NONE   = 3'd4
    } fu_type_e;

    ////////////////////////////////////////////////////////////
    // instruction word formats
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    // branch offset bits are scattered, bit 0 implied
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic        imm20;
        logic [9:0]  imm10_1;
        logic        imm11;
        logic [7:0]  imm19_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_t;

endpackage

`default_nettype wire

//--- source/pipe_pkg.sv
// Pipeline packet types
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // register zero, target of instructions with no destination
    localparam logic [4:0] zero_reg = 5'd0;

    ////////////////////////////////////////////////////////////
    // fetch to decode
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        inst_t       inst;
        logic [31:0] pc;
        logic [31:0] npc;
        logic        pred_taken;
        logic        valid;
    } inst_packet_t;

    // control fields of one decoder
    typedef struct packed {
        fu_type_e  fu_type;
        opa_sel_e  opa_select;
        opb_sel_e  opb_select;
        alu_func_e alu_func;
        logic      mult;
        logic      rd_mem;
        logic      wr_mem;
        logic      cond_branch;
        logic      uncond_branch;
        logic      csr_op;
        logic      halt;
        logic      illegal;
    } decode_ctrl_t;

    ////////////////////////////////////////////////////////////
    // decode output
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        inst_t       inst;
        logic [31:0] pc;
        logic [31:0] npc;
        logic        pred_taken;
        logic        valid;
        fu_type_e    fu_type;
        opa_sel_e    opa_select;
        opb_sel_e    opb_select;
        alu_func_e   alu_func;
        logic [4:0]  reg1;
        logic [4:0]  reg2;
        logic [4:0]  dest_reg_idx;
        logic [31:0] imm;
        logic        mult;
        logic        rd_mem;
        logic        wr_mem;
        logic        cond_branch;
        logic        uncond_branch;
        logic        csr_op;
        logic        halt;
        logic        illegal;
    } decoded_packet_t;

endpackage

`default_nettype wire

//--- source/inst_decoder.sv
// Single instruction decoder
`default_nettype none

module inst_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  inst_t        inst,
    output decode_ctrl_t ctrl,
    output logic         has_dest
);

    // idle control, also what an illegal word falls back to
    localparam decode_ctrl_t ctrl_nop = '{
        fu_type:       FU_NONE,
        opa_select:    OPA_IS_ZERO,
        opb_select:    OPB_IS_I_IMM,
        alu_func:      ADD,
        mult:          1'b0,
        rd_mem:        1'b0,
        wr_mem:        1'b0,
        cond_branch:   1'b0,
        uncond_branch: 1'b0,
        csr_op:        1'b0,
        halt:          1'b0,
        illegal:       1'b0
    };

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = inst.r.funct3;
    assign funct7 = inst.r.funct7;

    // shared funct3 map of OP and OP_IMM, alt picks SUB or SRA
    function automatic alu_func_e base_alu(input logic [2:0] f3, input logic alt);
        alu_func_e func;
        case (f3)
            3'b000:  func = alt ? SUB : ADD;
            3'b001:  func = SLL;
            3'b010:  func = SLT;
            3'b011:  func = SLTU;
            3'b100:  func = XOR;
            3'b101:  func = alt ? SRA : SRL;
            3'b110:  func = OR;
            default: func = AND;
        endcase
        return func;
    endfunction

    ////////////////////////////////////////////////////////////
    // opcode, then funct3 and funct7
    ////////////////////////////////////////////////////////////

    always_comb begin
        ctrl     = ctrl_nop;
        has_dest = 1'b0;

        case (inst.r.opcode)
            OP: begin
                ctrl.opa_select = OPA_IS_RS1;
                ctrl.opb_select = OPB_IS_RS2;
                has_dest        = 1'b1;
                if (funct7 == funct7_muldiv) begin
                    // M extension, divide is not supported
                    ctrl.fu_type = FU_MULT;
                    ctrl.mult    = 1'b1;
                    case (funct3)
                        3'b000:  ctrl.alu_func = MUL;
                        3'b001:  ctrl.alu_func = MULH;
                        3'b010:  ctrl.alu_func = MULHSU;
                        3'b011:  ctrl.alu_func = MULHU;
                        default: ctrl.illegal  = 1'b1;
                    endcase
                end else begin
                    ctrl.fu_type  = FU_ALU;
                    ctrl.alu_func = base_alu(funct3, funct7 == funct7_alt);
                    // alt form only exists for SUB and SRA
                    if (funct7 == funct7_alt) begin
                        ctrl.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                    end else if (funct7 != funct7_base) begin
                        ctrl.illegal = 1'b1;
                    end
                end
            end
            OP_IMM: begin
                ctrl.fu_type    = FU_ALU;
                ctrl.opa_select = OPA_IS_RS1;
                ctrl.opb_select = OPB_IS_I_IMM;
                has_dest        = 1'b1;
                ctrl.alu_func   = base_alu(funct3, 1'b0);
                // shift amounts carry funct7 in the upper immediate
                if (funct3 == 3'b001) begin
                    ctrl.illegal = funct7 != funct7_base;
                end else if (funct3 == 3'b101) begin
                    ctrl.alu_func = (funct7 == funct7_alt) ? SRA : SRL;
                    ctrl.illegal  = (funct7 != funct7_base) && (funct7 != funct7_alt);
                end
            end
            LOAD: begin
                ctrl.fu_type    = FU_LSU;
                ctrl.opa_select = OPA_IS_RS1;
                ctrl.opb_select = OPB_IS_I_IMM;
                ctrl.rd_mem     = 1'b1;
                has_dest        = 1'b1;
                // lb lh lw lbu lhu
                ctrl.illegal    = (funct3 == 3'b011) || (funct3 >= 3'b110);
            end
            STORE: begin
                ctrl.fu_type    = FU_LSU;
                ctrl.opa_select = OPA_IS_RS1;
                ctrl.opb_select = OPB_IS_RS2;
                ctrl.wr_mem     = 1'b1;
                ctrl.illegal    = funct3 > 3'b010;
            end
            BRANCH: begin
                ctrl.fu_type     = FU_BRANCH;
                ctrl.opa_select  = OPA_IS_RS1;
                ctrl.opb_select  = OPB_IS_RS2;
                ctrl.cond_branch = 1'b1;
                ctrl.illegal     = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            JAL: begin
                ctrl.fu_type       = FU_BRANCH;
                ctrl.opa_select    = OPA_IS_PC;
                ctrl.opb_select    = OPB_IS_J_IMM;
                ctrl.uncond_branch = 1'b1;
                has_dest           = 1'b1;
            end
            JALR: begin
                ctrl.fu_type       = FU_BRANCH;
                ctrl.opa_select    = OPA_IS_RS1;
                ctrl.opb_select    = OPB_IS_I_IMM;
                ctrl.uncond_branch = 1'b1;
                has_dest           = 1'b1;
                ctrl.illegal       = funct3 != 3'b000;
            end
            LUI: begin
                ctrl.fu_type    = FU_ALU;
                ctrl.opb_select = OPB_IS_U_IMM;
                has_dest        = 1'b1;
            end
            AUIPC: begin
                ctrl.fu_type    = FU_ALU;
                ctrl.opa_select = OPA_IS_PC;
                ctrl.opb_select = OPB_IS_U_IMM;
                has_dest        = 1'b1;
            end
            SYSTEM: begin
                case (funct3)
                    3'b000: begin
                        ctrl.halt    = inst == wfi_inst;
                        ctrl.illegal = inst != wfi_inst;
                    end
                    // register forms read rs1
                    3'b001, 3'b010, 3'b011: begin
                        ctrl.fu_type    = FU_ALU;
                        ctrl.opa_select = OPA_IS_RS1;
                        ctrl.csr_op     = 1'b1;
                        has_dest        = 1'b1;
                    end
                    // immediate forms, rs1 field is a uimm
                    3'b101, 3'b110, 3'b111: begin
                        ctrl.fu_type = FU_ALU;
                        ctrl.csr_op  = 1'b1;
                        has_dest     = 1'b1;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            MISC_MEM: begin
                // fence and fence.i, no work here
                ctrl.illegal = funct3 > 3'b001;
            end
            default: ctrl.illegal = 1'b1;
        endcase

        // bad encoding drops everything found so far
        if (ctrl.illegal) begin
            ctrl         = ctrl_nop;
            ctrl.illegal = 1'b1;
            has_dest     = 1'b0;
        end

        a_mem_exclusive: assert (!(ctrl.rd_mem && ctrl.wr_mem))
            else $error("inst_decoder: load and store flagged together");
    end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
// N-lane decode stage
`default_nettype none

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int N = 2
) (
    input  inst_packet_t    held      [N],
    output decoded_packet_t id_packet [N]
);

    decode_ctrl_t ctrl     [N];
    logic         has_dest [N];

    // sign-extended immediate of the word's format
    function automatic logic [31:0] build_imm(input inst_t word, input opb_sel_e sel);
        logic [31:0] i_imm;
        logic [31:0] s_imm;
        logic [31:0] b_imm;
        logic [31:0] u_imm;
        logic [31:0] j_imm;
        logic [31:0] imm;
        i_imm = {{20{word.i.imm[11]}}, word.i.imm};
        s_imm = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
        b_imm = {{19{word.b.imm12}}, word.b.imm12, word.b.imm11,
                 word.b.imm10_5, word.b.imm4_1, 1'b0};
        u_imm = {word.u.imm, 12'b0};
        j_imm = {{11{word.j.imm20}}, word.j.imm20, word.j.imm19_12,
                 word.j.imm11, word.j.imm10_1, 1'b0};
        case (sel)
            OPB_IS_I_IMM: imm = i_imm;
            OPB_IS_S_IMM: imm = s_imm;
            OPB_IS_B_IMM: imm = b_imm;
            OPB_IS_U_IMM: imm = u_imm;
            OPB_IS_J_IMM: imm = j_imm;
            default: begin
                // rs2 on operand B, format comes from the opcode
                case (word.r.opcode)
                    STORE:   imm = s_imm;
                    BRANCH:  imm = b_imm;
                    default: imm = '0;
                endcase
            end
        endcase
        return imm;
    endfunction

    ////////////////////////////////////////////////////////////
    // one decoder per lane
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < N; i++) begin : g_lane
        inst_decoder inst_decoder_inst (
            .inst     (held[i].inst),
            .ctrl     (ctrl[i]),
            .has_dest (has_dest[i])
        );
    end

    ////////////////////////////////////////////////////////////
    // packet assembly
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N; i++) begin
            // fetch fields pass straight through
            id_packet[i].inst       = held[i].inst;
            id_packet[i].pc         = held[i].pc;
            id_packet[i].npc        = held[i].npc;
            id_packet[i].pred_taken = held[i].pred_taken;
            id_packet[i].valid      = held[i].valid;

            id_packet[i].fu_type       = ctrl[i].fu_type;
            id_packet[i].opa_select    = ctrl[i].opa_select;
            id_packet[i].opb_select    = ctrl[i].opb_select;
            id_packet[i].alu_func      = ctrl[i].alu_func;
            id_packet[i].mult          = ctrl[i].mult;
            id_packet[i].rd_mem        = ctrl[i].rd_mem;
            id_packet[i].wr_mem        = ctrl[i].wr_mem;
            id_packet[i].cond_branch   = ctrl[i].cond_branch;
            id_packet[i].uncond_branch = ctrl[i].uncond_branch;
            id_packet[i].csr_op        = ctrl[i].csr_op;
            id_packet[i].halt          = ctrl[i].halt;
            id_packet[i].illegal       = ctrl[i].illegal;

            // unused sources read as register zero
            id_packet[i].reg1 = (ctrl[i].opa_select == OPA_IS_RS1) ?
                                held[i].inst.r.rs1 : zero_reg;
            id_packet[i].reg2 = (ctrl[i].opb_select == OPB_IS_RS2) ?
                                held[i].inst.r.rs2 : zero_reg;
            id_packet[i].dest_reg_idx = has_dest[i] ? held[i].inst.r.rd : zero_reg;
            id_packet[i].imm = build_imm(held[i].inst, ctrl[i].opb_select);

            a_illegal_no_dest: assert (!id_packet[i].illegal ||
                                       id_packet[i].dest_reg_idx == zero_reg)
                else $error("decode_stage: illegal lane %0d writes a register", i);
        end
    end

endmodule

`default_nettype wire

//--- source/inst_reg.sv
// Fetch to decode instruction register
`default_nettype none

module inst_reg
    import pipe_pkg::*;
#(
    parameter int N = 2
) (
    input  logic         clock,
    input  logic         arst_n,
    input  logic         stall,
    input  logic         flush,
    input  inst_packet_t insts [N],
    output inst_packet_t held  [N]
);

    logic [N-1:0] held_valid;

    ////////////////////////////////////////////////////////////
    // lane registers
    ////////////////////////////////////////////////////////////

    // flush wins over stall, and only drops the valid bits
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N; i++) begin
                held[i] <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < N; i++) begin
                held[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            held <= insts;
        end
    end

    // valid bits gathered for the check below
    always_comb begin
        for (int i = 0; i < N; i++) begin
            held_valid[i] = held[i].valid;
        end
    end

    a_flush_clears: assert property (
        @(posedge clock) disable iff (!arst_n)
        flush |=> held_valid == '0
    ) else $error("inst_reg: valid lane survived a flush");

endmodule

`default_nettype wire

//--- source/decode_top.sv
// Superscalar decode top level
`default_nettype none

module decode_top
    import pipe_pkg::*;
#(
    parameter int N = 2
) (
    input  logic            clock,
    input  logic            arst_n,
    input  inst_packet_t    insts     [N],
    input  logic            stall,
    input  logic            flush,
    output decoded_packet_t id_packet [N]
);

    // registered fetch packets feeding decode
    inst_packet_t held [N];

    inst_reg #(
        .N (N)
    ) inst_reg_inst (
        .clock  (clock),
        .arst_n (arst_n),
        .stall  (stall),
        .flush  (flush),
        .insts  (insts),
        .held   (held)
    );

    // decode is combinational off the register
    decode_stage #(
        .N (N)
    ) decode_stage_inst (
        .held      (held),
        .id_packet (id_packet)
    );

endmodule

`default_nettype wire

//--- bench/decode_tb.sv
// Superscalar decode testbench
`default_nettype none

module decode_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    N             = 2;
    localparam int    reset_timeout = 20;
    localparam string cases_path    = "bench/decode_cases.txt";

    logic            clock;
    logic            arst_n;
    logic            stall;
    logic            flush;
    inst_packet_t    insts     [N];
    decoded_packet_t id_packet [N];

    // model of what the register holds in each lane
    decoded_packet_t expected   [N];
    logic            word_known [N];
    int              fd;
    int              steps_done;

    decode_top #(
        .N (N)
    ) decode_top_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .insts     (insts),
        .stall     (stall),
        .flush     (flush),
        .id_packet (id_packet)
    );

    ////////////////////////////////////////////////////////////
    // clock and reset
    ////////////////////////////////////////////////////////////

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // two cycles low then released off the edge like other inputs
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clock);
        #10;
        arst_n = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compare_field(input string name, input int lane,
                                 input logic [31:0] exp_val, input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            abort_run($sformatf("** Error: id_packet[%0d].%s expected %h got %h",
                                lane, name, exp_val, act_val));
        end
    endtask

    task automatic check_ctrl(input int lane, input decoded_packet_t exp_pkt,
                              input decoded_packet_t act_pkt);
        compare_field("fu_type", lane, 32'(exp_pkt.fu_type), 32'(act_pkt.fu_type));
        compare_field("opa_select", lane, 32'(exp_pkt.opa_select), 32'(act_pkt.opa_select));
        compare_field("opb_select", lane, 32'(exp_pkt.opb_select), 32'(act_pkt.opb_select));
        compare_field("alu_func", lane, 32'(exp_pkt.alu_func), 32'(act_pkt.alu_func));
        compare_field("mult", lane, 32'(exp_pkt.mult), 32'(act_pkt.mult));
        compare_field("rd_mem", lane, 32'(exp_pkt.rd_mem), 32'(act_pkt.rd_mem));
        compare_field("wr_mem", lane, 32'(exp_pkt.wr_mem), 32'(act_pkt.wr_mem));
        compare_field("cond_branch", lane, 32'(exp_pkt.cond_branch),
                      32'(act_pkt.cond_branch));
        compare_field("uncond_branch", lane, 32'(exp_pkt.uncond_branch),
                      32'(act_pkt.uncond_branch));
        compare_field("csr_op", lane, 32'(exp_pkt.csr_op), 32'(act_pkt.csr_op));
        compare_field("halt", lane, 32'(exp_pkt.halt), 32'(act_pkt.halt));
        compare_field("illegal", lane, 32'(exp_pkt.illegal), 32'(act_pkt.illegal));
    endtask

    task automatic check_regs(input int lane, input decoded_packet_t exp_pkt,
                              input decoded_packet_t act_pkt);
        compare_field("reg1", lane, 32'(exp_pkt.reg1), 32'(act_pkt.reg1));
        compare_field("reg2", lane, 32'(exp_pkt.reg2), 32'(act_pkt.reg2));
        compare_field("dest_reg_idx", lane, 32'(exp_pkt.dest_reg_idx),
                      32'(act_pkt.dest_reg_idx));
    endtask

    task automatic check_imm(input int lane, input decoded_packet_t exp_pkt,
                             input decoded_packet_t act_pkt);
        compare_field("imm", lane, exp_pkt.imm, act_pkt.imm);
    endtask

    task automatic check_pass(input int lane, input decoded_packet_t exp_pkt,
                              input decoded_packet_t act_pkt);
        compare_field("inst", lane, 32'(exp_pkt.inst), 32'(act_pkt.inst));
        compare_field("pc", lane, exp_pkt.pc, act_pkt.pc);
        compare_field("npc", lane, exp_pkt.npc, act_pkt.npc);
        compare_field("pred_taken", lane, 32'(exp_pkt.pred_taken), 32'(act_pkt.pred_taken));
        compare_field("valid", lane, 32'(exp_pkt.valid), 32'(act_pkt.valid));
    endtask

    // random words of invalid lanes have no decode to compare
    task automatic check_lanes();
        for (int l = 0; l < N; l++) begin
            check_pass(l, expected[l], id_packet[l]);
            if (word_known[l]) begin
                check_ctrl(l, expected[l], id_packet[l]);
                check_regs(l, expected[l], id_packet[l]);
                check_imm(l, expected[l], id_packet[l]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // cases file
    ////////////////////////////////////////////////////////////

    // next data line with comment lines skipped
    task automatic read_case(output logic found, output int lane, output logic stall_v,
                             output logic flush_v, output logic [31:0] word,
                             output logic pred, output logic valid_v,
                             output decoded_packet_t exp_pkt);
        string       line;
        int          step;
        int          cnt;
        logic [31:0] st;
        logic [31:0] fl;
        logic [31:0] pr;
        logic [31:0] va;
        logic [31:0] fu;
        logic [31:0] opa;
        logic [31:0] opb;
        logic [31:0] alu;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] rd;
        logic [31:0] imm;
        logic [31:0] flags;
        found   = 1'b0;
        lane    = 0;
        exp_pkt = '0;
        while (!found) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          step, lane, st, fl, word, pr, va, fu, opa, opb, alu,
                          r1, r2, rd, imm, flags);
            if (cnt != 16) begin
                abort_run("cases file has a malformed line");
            end
            found = 1'b1;
        end
        stall_v                = st[0];
        flush_v                = fl[0];
        pred                   = pr[0];
        valid_v                = va[0];
        exp_pkt.fu_type        = fu_type_e'(fu[2:0]);
        exp_pkt.opa_select     = opa_sel_e'(opa[1:0]);
        exp_pkt.opb_select     = opb_sel_e'(opb[2:0]);
        exp_pkt.alu_func       = alu_func_e'(alu[3:0]);
        exp_pkt.reg1           = r1[4:0];
        exp_pkt.reg2           = r2[4:0];
        exp_pkt.dest_reg_idx   = rd[4:0];
        exp_pkt.imm            = imm;
        // flag mask from bit 7 down to bit 0
        exp_pkt.mult           = flags[7];
        exp_pkt.rd_mem         = flags[6];
        exp_pkt.wr_mem         = flags[5];
        exp_pkt.cond_branch    = flags[4];
        exp_pkt.uncond_branch  = flags[3];
        exp_pkt.csr_op         = flags[2];
        exp_pkt.halt           = flags[1];
        exp_pkt.illegal        = flags[0];
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        decoded_packet_t loaded       [N];
        logic            loaded_known [N];
        decoded_packet_t file_pkt;
        logic            found;
        int              lane;
        int              waited;
        logic            st;
        logic            fl;
        logic            pred;
        logic            vld;
        logic            step_stall;
        logic            step_flush;
        logic [31:0]     word;
        logic [31:0]     rnd;

        // stall keeps the reset contents over the first edge after release
        stall      = 1'b1;
        flush      = 1'b0;
        step_stall = 1'b0;
        step_flush = 1'b0;
        steps_done = 0;
        for (int l = 0; l < N; l++) begin
            insts[l]       = '0;
            insts[l].valid = 1'b1;
            expected[l]    = '0;
            word_known[l]  = 1'b0;
        end
        void'($urandom(78848));

        fd = $fopen(cases_path, "r");
        if (fd == 0) begin
            abort_run("could not open bench/decode_cases.txt for reading");
        end

        // bounded wait for reset release
        waited = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clock);
            waited++;
            if (waited > reset_timeout) begin
                abort_run("reset was never released");
            end
        end
        // empty register right after reset
        #5;
        check_lanes();
        #5;

        found = 1'b1;
        while (found) begin
            for (int l = 0; l < N; l++) begin
                read_case(found, lane, st, fl, word, pred, vld, file_pkt);
                if (!found) begin
                    if (l != 0) begin
                        abort_run("cases file ends in the middle of a step");
                    end
                    break;
                end
                if (lane != l) begin
                    abort_run("cases file lanes are out of order");
                end
                step_stall = st;
                step_flush = fl;
                rnd        = $urandom;
                insts[l].pc         = {rnd[31:2], 2'b00};
                insts[l].npc        = {rnd[31:2], 2'b00} + 32'd4;
                insts[l].pred_taken = pred;
                insts[l].valid      = vld;
                if (vld) begin
                    insts[l].inst = word;
                end else begin
                    insts[l].inst = $urandom;
                end
                loaded[l]            = file_pkt;
                loaded[l].inst       = insts[l].inst;
                loaded[l].pc         = insts[l].pc;
                loaded[l].npc        = insts[l].npc;
                loaded[l].pred_taken = pred;
                loaded[l].valid      = vld;
                loaded_known[l]      = vld;
            end
            if (found) begin
                stall = step_stall;
                flush = step_flush;
                // flush drops only valid and stall keeps everything
                for (int l = 0; l < N; l++) begin
                    if (step_flush) begin
                        expected[l].valid = 1'b0;
                    end else if (!step_stall) begin
                        expected[l]   = loaded[l];
                        word_known[l] = loaded_known[l];
                    end
                end
                @(posedge clock);
                #5;
                check_lanes();
                steps_done++;
                #5;
            end
        end
        $fclose(fd);

        if (steps_done > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run("no steps found in the cases file");
        end
    end

endmodule

`default_nettype wire

//--- bench/decode_cases.txt
# step lane stall flush inst pred_taken valid fu opa opb alu reg1 reg2 dest imm flags
# hex except step and lane; flags bit7..0 = mult rd_mem wr_mem cond uncond csr halt illegal
# stall and flush rows repeat the held values; words of invalid lanes are random
1 0 0 0 002081b3 0 1 0 0 0 0 01 02 03 00000000 00
1 1 0 0 407302b3 0 1 0 0 0 1 06 07 05 00000000 00
2 0 0 0 02c58533 0 1 1 0 0 a 0b 0c 0a 00000000 80
2 1 0 0 023130b3 0 1 1 0 0 d 02 03 01 00000000 80
3 0 0 0 4062d233 0 1 0 0 0 9 05 06 04 00000000 00
3 1 0 0 009433b3 0 1 0 0 0 3 08 09 07 00000000 00
4 0 0 0 fff10093 0 1 0 0 1 0 02 00 01 ffffffff 00
4 1 0 0 00832283 0 1 2 0 1 0 06 00 05 00000008 40
5 0 0 0 fe742e23 0 1 2 0 0 0 08 07 00 fffffffc 20
5 1 0 0 fe208ce3 1 1 3 0 0 0 01 02 00 fffffff8 10
6 0 0 0 abcde4b7 0 1 0 3 4 0 00 00 09 abcde000 00
6 1 0 0 00010117 0 1 0 2 4 0 00 00 02 00010000 00
7 0 0 0 ffdff0ef 1 1 3 2 5 0 00 00 01 fffffffc 08
7 1 0 0 010082e7 0 1 3 0 1 0 01 00 05 00000010 08
8 0 0 0 0000007f 0 1 4 3 1 0 00 00 00 00000000 01
8 1 0 0 202081b3 0 1 4 3 1 0 00 00 00 00000202 01
9 0 0 0 10500073 0 1 4 3 1 0 00 00 00 00000105 02
9 1 0 0 300312f3 0 1 0 0 1 0 06 00 05 00000300 04
10 0 0 0 00000000 0 0 0 0 0 0 00 00 00 00000000 00
10 1 0 0 7ff1e113 1 1 0 0 1 5 03 00 02 000007ff 00
11 0 1 0 002081b3 0 1 0 0 0 0 00 00 00 00000000 00
11 1 1 0 407302b3 0 1 0 0 1 5 03 00 02 000007ff 00
12 0 1 1 00832283 0 1 0 0 0 0 00 00 00 00000000 00
12 1 1 1 fe208ce3 1 1 0 0 1 5 03 00 02 000007ff 00
13 0 0 0 00309093 0 1 0 0 1 7 01 00 01 00000003 00
13 1 0 0 4022d213 0 1 0 0 1 9 05 00 04 00000402 00
14 0 0 1 02c58533 0 1 0 0 1 7 01 00 01 00000003 00
14 1 0 1 abcde4b7 0 1 0 0 1 9 05 00 04 00000402 00
15 0 0 0 023110b3 0 1 1 0 0 b 02 03 01 00000000 80
15 1 0 0 023140b3 1 1 4 3 1 0 00 00 00 00000023 01
16 0 0 0 fe742e23 1 1 2 0 0 0 08 07 00 fffffffc 20
16 1 0 0 00000000 0 0 0 0 0 0 00 00 00 00000000 00

//--- superscalar_decode.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/inst_decoder.sv
source/decode_stage.sv
source/inst_reg.sv
source/decode_top.sv
bench/decode_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the decode testbench with Verilator and run it from the project root
# a failing check ends in $fatal, which gives a nonzero exit status

cd "$(dirname "$0")" && \
verilator --binary --assert --timescale 1ns/1ps \
    --top-module decode_tb \
    -f superscalar_decode.f \
    -o decode_sim && \
./obj_dir/decode_sim || {
    echo "decode simulation did not pass"
    exit 1
}
